//--- project.f
cache_pkg.sv
cache_wtb.sv
cache_write_channel.sv
cache_read_channel.sv
cache_back_end.sv
cache_memory_side.sv
tb_clock_gen.sv
tb_cache_memory_side.sv

//--- Bender.yml
package:
  name: cache_memory_side

sources:
  - cache_pkg.sv
  - cache_wtb.sv
  - cache_write_channel.sv
  - cache_read_channel.sv
  - cache_back_end.sv
  - cache_memory_side.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_cache_memory_side.sv

//--- tb_cache_memory_side.sv
`timescale 1ns/1ps

module tb_cache_memory_side;

   localparam int ADDR_W        = cache_pkg::ADDR_W;
   localparam int LINE2BE_W     = cache_pkg::LINE2BE_W;
   localparam int WTB_DEPTH_W   = cache_pkg::WTB_DEPTH_W;
   localparam int DATA_W        = cache_pkg::DATA_W;
   localparam int WA_W          = ADDR_W - cache_pkg::NBYTES_W;   // Word address bits
   localparam int LA_W          = WA_W - LINE2BE_W;               // Line address bits
   localparam int BEATS         = 2 ** LINE2BE_W;
   localparam int DEPTH         = 2 ** WTB_DEPTH_W;
   localparam int CLK_PERIOD_NS = 40;
   localparam int N_RAND        = 24;
   localparam int N_STALL       = DEPTH + 2;
   localparam int N_MERGE       = 5;
   localparam int N_TRANS       = N_RAND + N_STALL + N_MERGE + 3 * BEATS;
   localparam int MEM_WORDS     = 4096;
   localparam logic [31:0] SEED = 32'he330_8fd9;

   logic                         clk_i;
   logic                         rst_n;
   logic                         write_valid;
   logic [WA_W-1:0]              write_addr;
   logic [DATA_W-1:0]            write_wdata;
   logic [cache_pkg::NBYTES-1:0] write_wstrb;
   logic                         write_ready;
   logic                         replace_valid;
   logic [LA_W-1:0]              replace_addr;
   logic                         replace;
   logic                         read_valid;
   logic [LINE2BE_W-1:0]         read_addr;
   logic [DATA_W-1:0]            read_rdata;
   logic                         be_valid;
   logic [ADDR_W-1:0]            be_addr;
   logic [DATA_W-1:0]            be_wdata;
   logic [cache_pkg::NBYTES-1:0] be_wstrb;
   logic [DATA_W-1:0]            be_rdata   = '0;
   logic                         be_ready   = 1'b0;
   logic                         hold_ready = 1'b0;   // Stalls the back end

   logic [WA_W-1:0]              exp_addr [$];
   logic [DATA_W-1:0]            exp_data [$];
   logic [cache_pkg::NBYTES-1:0] exp_strb [$];
   logic [WA_W-1:0]              wr_log   [$];
   logic [DATA_W-1:0]            mem            [MEM_WORDS];
   logic [DATA_W-1:0]            shadow         [MEM_WORDS];
   bit                           mem_written    [MEM_WORDS];
   bit                           shadow_written [MEM_WORDS];
   logic [LA_W-1:0]              fill_line_q;
   logic [31:0]                  stim_state  = SEED;
   logic [31:0]                  mem_state   = SEED;
   int                           beat_cnt    = 0;
   int                           acc_total   = 0;
   int                           wait_left   = 0;
   int                           check_count = 0;
   int                           error_count = 0;

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD_NS),
      .RESET_CYCLES (2)
   ) clock_gen (
      .clk_i (clk_i),
      .rst_n (rst_n)
   );

   cache_memory_side #(
      .ADDR_W      (ADDR_W),
      .LINE2BE_W   (LINE2BE_W),
      .WTB_DEPTH_W (WTB_DEPTH_W)
   ) i_cache_memory_side (
      .clk_i         (clk_i),
      .rst_n         (rst_n),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid),
      .be_addr       (be_addr),
      .be_wdata      (be_wdata),
      .be_wstrb      (be_wstrb),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Background memory contents
   function automatic logic [DATA_W-1:0] fill_pattern(input logic [WA_W-1:0] wa);
      return {wa[15:0], wa[WA_W-1:WA_W-16]} ^ 32'h5a0f_c3e1;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] data,
                                                     input logic [3:0]        strb);
      logic [DATA_W-1:0] res;
      int                i;
      res = old;
      for (i = 0; i < 4; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = data[8*i +: 8];
         end
      end
      return res;
   endfunction

   // Expected word, all accepted writes applied in order
   function automatic logic [DATA_W-1:0] ref_word(input logic [WA_W-1:0] wa);
      if (shadow_written[wa[11:0]]) begin
         return shadow[wa[11:0]];
      end
      return fill_pattern(wa);
   endfunction

   function automatic logic [DATA_W-1:0] mem_word(input logic [WA_W-1:0] wa);
      if (mem_written[wa[11:0]]) begin
         return mem[wa[11:0]];
      end
      return fill_pattern(wa);
   endfunction

   task automatic compare(input string what, input logic [63:0] got,
                          input logic [63:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("ERROR %0d ns: %s expected %0h, got %0h", $time, what, expected, got);
      end
   endtask

   task automatic report(input string name, input int errs_before);
      if (error_count == errs_before) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: %0d errors", name, error_count - errs_before);
      end
   endtask

   task automatic offer_random(input logic [WA_W-1:0] base);
      logic [3:0] strb;
      stim_state = lcg_step(stim_state);
      write_addr <= base + stim_state[21:16];
      stim_state = lcg_step(stim_state);
      write_wdata <= stim_state;
      stim_state = lcg_step(stim_state);
      strb = stim_state[27:24];
      write_wstrb <= (strb == 4'b0000) ? 4'b1111 : strb;   // Zero strobe marks a read
      write_valid <= 1'b1;
   endtask

   task automatic wait_accept();
      do begin
         @(posedge clk_i);
      end while (!write_ready);
   endtask

   task automatic write_word(input logic [WA_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [3:0] s);
      write_addr  <= a;
      write_wdata <= d;
      write_wstrb <= s;
      write_valid <= 1'b1;
      wait_accept();
      write_valid <= 1'b0;
   endtask

   task automatic drain();
      do begin
         @(posedge clk_i);
      end while (exp_addr.size() != 0 || be_valid);
   endtask

   task automatic request_fill(input logic [LA_W-1:0] line);
      fill_line_q = line;
      beat_cnt    = 0;
      replace_valid <= 1'b1;
      replace_addr  <= line;
      do begin
         @(posedge clk_i);
      end while (!replace);
      replace_valid <= 1'b0;
      do begin
         @(posedge clk_i);
      end while (replace);
      compare("beats in fill", beat_cnt, BEATS);
   endtask

   // Back-end memory, 0 to 3 wait cycles before each be_ready
   always @(posedge clk_i) begin
      if (be_ready) begin
         be_ready <= 1'b0;
         mem_state = lcg_step(mem_state);
         wait_left = mem_state[25:24];
      end else if (be_valid && !hold_ready) begin
         if (wait_left > 0) begin
            wait_left--;
         end else begin
            be_ready <= 1'b1;
            if (be_wstrb != '0) begin
               mem[be_addr[13:2]] = merge_bytes(mem_word(be_addr[ADDR_W-1:2]), be_wdata,
                                                be_wstrb);
               mem_written[be_addr[13:2]] = 1'b1;
               wr_log.push_back(be_addr[ADDR_W-1:2]);
            end else begin
               be_rdata <= mem_word(be_addr[ADDR_W-1:2]);
            end
         end
      end
   end

   always @(posedge clk_i) begin
      if (rst_n) begin
         if (write_valid && write_ready) begin
            exp_addr.push_back(write_addr);
            exp_data.push_back(write_wdata);
            exp_strb.push_back(write_wstrb);
            shadow[write_addr[11:0]] = merge_bytes(ref_word(write_addr), write_wdata,
                                                   write_wstrb);
            shadow_written[write_addr[11:0]] = 1'b1;
            acc_total++;
         end
         if (be_valid && be_ready && be_wstrb != '0) begin
            if (exp_addr.size() == 0) begin
               error_count++;
               $display("ERROR %0d ns: back-end write with no accepted write left", $time);
            end else begin
               compare("be_addr", be_addr, {exp_addr[0], {cache_pkg::NBYTES_W{1'b0}}});
               compare("be_wdata", be_wdata, exp_data[0]);
               compare("be_wstrb", be_wstrb, exp_strb[0]);
               void'(exp_addr.pop_front());
               void'(exp_data.pop_front());
               void'(exp_strb.pop_front());
            end
         end
         if (read_valid) begin
            compare("read_addr", read_addr, beat_cnt);
            compare("fill be_addr", be_addr,
                    {fill_line_q, beat_cnt[LINE2BE_W-1:0], {cache_pkg::NBYTES_W{1'b0}}});
            compare("read_rdata", read_rdata,
                    ref_word({fill_line_q, beat_cnt[LINE2BE_W-1:0]}));
            compare("writes pending during fill", exp_addr.size(), 0);
            beat_cnt++;
         end
      end
   end

   initial begin
      #(N_TRANS * 20 * CLK_PERIOD_NS);
      $display("Timeout: the tests did not finish within %0d ns", N_TRANS * 20 * CLK_PERIOD_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      int errs;
      int accepted;
      write_valid   = 1'b0;
      write_addr    = '0;
      write_wdata   = '0;
      write_wstrb   = '0;
      replace_valid = 1'b0;
      replace_addr  = '0;
      wait (rst_n === 1'b1);
      @(posedge clk_i);

      errs = error_count;
      compare("write_ready after reset", write_ready, 1);
      compare("replace after reset", replace, 0);
      compare("read_valid after reset", read_valid, 0);
      compare("be_valid after reset", be_valid, 0);
      compare("be_wstrb after reset", be_wstrb, 0);
      report("reset state", errs);

      errs = error_count;
      repeat (N_RAND) begin
         offer_random('h400);
         wait_accept();
      end
      write_valid <= 1'b0;
      drain();
      compare("writes logged", wr_log.size(), acc_total);
      report("write-through order", errs);

      errs = error_count;
      accepted = 0;
      hold_ready <= 1'b1;
      @(posedge clk_i);
      offer_random('h500);
      repeat (8) begin
         @(posedge clk_i);
         if (write_ready) begin
            accepted++;
            offer_random('h500);
         end
      end
      compare("writes accepted while stalled", accepted, DEPTH + 1);
      compare("write_ready while stalled", write_ready, 0);
      hold_ready <= 1'b0;
      wait_accept();
      write_valid <= 1'b0;
      drain();
      compare("writes logged", wr_log.size(), acc_total);
      report("buffer back-pressure", errs);

      errs = error_count;
      request_fill('h103);   // Line hit by the random writes
      request_fill('h3c7);
      report("line fill", errs);

      errs = error_count;
      write_word('ha94, 32'h1122_3344, 4'b0001);
      write_word('ha95, 32'h5566_7788, 4'b0110);
      write_word('ha96, 32'h99aa_bbcc, 4'b1000);
      write_word('ha95, 32'hdead_beef, 4'b1001);
      write_word('ha97, 32'h0f1e_2d3c, 4'b0101);
      request_fill('h2a5);   // Same line, still queued
      compare("writes logged", wr_log.size(), acc_total);
      report("write before fill", errs);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_i,
   output logic rst_n
);

   initial begin
      clk_i = 1'b0;
      forever #(PERIOD_NS / 2) clk_i = ~clk_i;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_n <= 1'b1;   // Released on a rising edge
   end

endmodule

//--- cache_memory_side.sv
`timescale 1ns/1ps

module cache_memory_side #(
   parameter int ADDR_W      = cache_pkg::ADDR_W,
   parameter int LINE2BE_W   = cache_pkg::LINE2BE_W,
   parameter int WTB_DEPTH_W = cache_pkg::WTB_DEPTH_W
) (
   input  logic                                           clk_i,
   input  logic                                           rst_n,

   input  logic                                           write_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W]            write_addr,
   input  logic [cache_pkg::DATA_W-1:0]                   write_wdata,
   input  logic [cache_pkg::NBYTES-1:0]                   write_wstrb,
   output logic                                           write_ready,

   input  logic                                           replace_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W+LINE2BE_W]  replace_addr,
   output logic                                           replace,
   output logic                                           read_valid,
   output logic [LINE2BE_W-1:0]                           read_addr,
   output logic [cache_pkg::DATA_W-1:0]                   read_rdata,

   output logic                                           be_valid,
   output logic [ADDR_W-1:0]                              be_addr,
   output logic [cache_pkg::DATA_W-1:0]                   be_wdata,
   output logic [cache_pkg::NBYTES-1:0]                   be_wstrb,
   input  logic [cache_pkg::DATA_W-1:0]                   be_rdata,
   input  logic                                           be_ready
);

   logic                                 entry_valid;
   logic [ADDR_W-1:cache_pkg::NBYTES_W]  entry_addr;
   logic [cache_pkg::DATA_W-1:0]         entry_wdata;
   logic [cache_pkg::NBYTES-1:0]         entry_wstrb;
   logic                                 entry_pop;
   logic                                 wtb_empty;

   cache_wtb #(
      .ADDR_W      (ADDR_W),
      .WTB_DEPTH_W (WTB_DEPTH_W)
   ) wtb (
      .clk_i       (clk_i),
      .rst_n       (rst_n),
      .write_valid (write_valid),
      .write_addr  (write_addr),
      .write_wdata (write_wdata),
      .write_wstrb (write_wstrb),
      .write_ready (write_ready),
      .entry_valid (entry_valid),
      .entry_addr  (entry_addr),
      .entry_wdata (entry_wdata),
      .entry_wstrb (entry_wstrb),
      .entry_pop   (entry_pop),
      .empty       (wtb_empty)
   );

   cache_back_end #(
      .ADDR_W    (ADDR_W),
      .LINE2BE_W (LINE2BE_W)
   ) back_end (
      .clk_i         (clk_i),
      .rst_n         (rst_n),
      .entry_valid   (entry_valid),
      .entry_addr    (entry_addr),
      .entry_wdata   (entry_wdata),
      .entry_wstrb   (entry_wstrb),
      .entry_pop     (entry_pop),
      .wtb_empty     (wtb_empty),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid),
      .be_addr       (be_addr),
      .be_wdata      (be_wdata),
      .be_wstrb      (be_wstrb),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

endmodule

//--- cache_back_end.sv
`timescale 1ns/1ps

module cache_back_end #(
   parameter int ADDR_W    = cache_pkg::ADDR_W,
   parameter int LINE2BE_W = cache_pkg::LINE2BE_W
) (
   input  logic                                           clk_i,
   input  logic                                           rst_n,

   input  logic                                           entry_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W]            entry_addr,
   input  logic [cache_pkg::DATA_W-1:0]                   entry_wdata,
   input  logic [cache_pkg::NBYTES-1:0]                   entry_wstrb,
   output logic                                           entry_pop,
   input  logic                                           wtb_empty,

   input  logic                                           replace_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W+LINE2BE_W]  replace_addr,
   output logic                                           replace,
   output logic                                           read_valid,
   output logic [LINE2BE_W-1:0]                           read_addr,
   output logic [cache_pkg::DATA_W-1:0]                   read_rdata,

   output logic                                           be_valid,
   output logic [ADDR_W-1:0]                              be_addr,
   output logic [cache_pkg::DATA_W-1:0]                   be_wdata,
   output logic [cache_pkg::NBYTES-1:0]                   be_wstrb,
   input  logic [cache_pkg::DATA_W-1:0]                   be_rdata,
   input  logic                                           be_ready
);

   logic              be_valid_read;
   logic              be_valid_write;
   logic [ADDR_W-1:0] be_addr_read;
   logic [ADDR_W-1:0] be_addr_write;
   logic              write_busy;
   logic              fill_allowed;
   logic              entry_valid_wr;

   // Line fill sees every earlier write
   assign fill_allowed = wtb_empty & ~write_busy;

   assign entry_valid_wr = entry_valid & ~replace;   // Writes wait while a fill runs

   assign be_valid = be_valid_read | be_valid_write;
   assign be_addr  = be_valid_read ? be_addr_read : be_addr_write;

   cache_read_channel #(
      .ADDR_W    (ADDR_W),
      .LINE2BE_W (LINE2BE_W)
   ) read_fsm (
      .clk_i         (clk_i),
      .rst_n         (rst_n),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .fill_allowed  (fill_allowed),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_valid      (be_valid_read),
      .be_addr       (be_addr_read),
      .be_rdata      (be_rdata),
      .be_ready      (be_ready)
   );

   cache_write_channel #(
      .ADDR_W (ADDR_W)
   ) write_fsm (
      .clk_i       (clk_i),
      .rst_n       (rst_n),
      .entry_valid (entry_valid_wr),
      .entry_addr  (entry_addr),
      .entry_wdata (entry_wdata),
      .entry_wstrb (entry_wstrb),
      .entry_pop   (entry_pop),
      .busy        (write_busy),
      .be_valid    (be_valid_write),
      .be_addr     (be_addr_write),
      .be_wdata    (be_wdata),
      .be_wstrb    (be_wstrb),
      .be_ready    (be_ready)
   );

endmodule

//--- cache_read_channel.sv
`timescale 1ns/1ps

module cache_read_channel #(
   parameter int ADDR_W    = cache_pkg::ADDR_W,
   parameter int LINE2BE_W = cache_pkg::LINE2BE_W
) (
   input  logic                                           clk_i,
   input  logic                                           rst_n,

   input  logic                                           replace_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W+LINE2BE_W]  replace_addr,
   input  logic                                           fill_allowed,
   output logic                                           replace,
   output logic                                           read_valid,
   output logic [LINE2BE_W-1:0]                           read_addr,
   output logic [cache_pkg::DATA_W-1:0]                   read_rdata,

   output logic                                           be_valid,
   output logic [ADDR_W-1:0]                              be_addr,
   input  logic [cache_pkg::DATA_W-1:0]                   be_rdata,
   input  logic                                           be_ready
);

   localparam logic IDLE = 1'b0;
   localparam logic FILL = 1'b1;

   logic                                          state;
   logic [ADDR_W-1:cache_pkg::NBYTES_W+LINE2BE_W] line_addr;
   logic [LINE2BE_W-1:0]                          beat;

   assign replace  = (state == FILL);
   assign be_valid = (state == FILL);
   assign be_addr  = {line_addr, beat, {cache_pkg::NBYTES_W{1'b0}}};

   // Each completed beat goes straight to the front end
   assign read_valid = (state == FILL) & be_ready;
   assign read_addr  = beat;
   assign read_rdata = be_rdata;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         beat  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (replace_valid && fill_allowed) begin
                  state <= FILL;
                  beat  <= '0;
               end
            end
            FILL: begin
               if (be_ready) begin
                  beat <= beat + 1'b1;   // Wraps to zero after the last beat
                  if (&beat) begin
                     state <= IDLE;
                  end
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == IDLE && replace_valid && fill_allowed) begin
         line_addr <= replace_addr;
      end
   end

endmodule

//--- cache_write_channel.sv
`timescale 1ns/1ps

module cache_write_channel #(
   parameter int ADDR_W = cache_pkg::ADDR_W
) (
   input  logic                                 clk_i,
   input  logic                                 rst_n,

   input  logic                                 entry_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W]  entry_addr,
   input  logic [cache_pkg::DATA_W-1:0]         entry_wdata,
   input  logic [cache_pkg::NBYTES-1:0]         entry_wstrb,
   output logic                                 entry_pop,

   output logic                                 busy,

   output logic                                 be_valid,
   output logic [ADDR_W-1:0]                    be_addr,
   output logic [cache_pkg::DATA_W-1:0]         be_wdata,
   output logic [cache_pkg::NBYTES-1:0]         be_wstrb,
   input  logic                                 be_ready
);

   localparam logic IDLE  = 1'b0;
   localparam logic WRITE = 1'b1;

   logic state;

   assign entry_pop = (state == IDLE) & entry_valid;
   assign busy      = (state == WRITE);
   assign be_valid  = (state == WRITE);

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state    <= IDLE;
         be_wstrb <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (entry_valid) begin
                  state    <= WRITE;
                  be_wstrb <= entry_wstrb;
               end
            end
            WRITE: begin
               if (be_ready) begin
                  state    <= IDLE;
                  be_wstrb <= '0;   // Back at zero so the read path sees no write
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk_i) begin
      if (entry_pop) begin
         be_addr  <= {entry_addr, {cache_pkg::NBYTES_W{1'b0}}};
         be_wdata <= entry_wdata;
      end
   end

endmodule

//--- cache_wtb.sv
`timescale 1ns/1ps

module cache_wtb #(
   parameter int ADDR_W      = cache_pkg::ADDR_W,
   parameter int WTB_DEPTH_W = cache_pkg::WTB_DEPTH_W
) (
   input  logic                                 clk_i,
   input  logic                                 rst_n,

   input  logic                                 write_valid,
   input  logic [ADDR_W-1:cache_pkg::NBYTES_W]  write_addr,
   input  logic [cache_pkg::DATA_W-1:0]         write_wdata,
   input  logic [cache_pkg::NBYTES-1:0]         write_wstrb,
   output logic                                 write_ready,

   output logic                                 entry_valid,
   output logic [ADDR_W-1:cache_pkg::NBYTES_W]  entry_addr,
   output logic [cache_pkg::DATA_W-1:0]         entry_wdata,
   output logic [cache_pkg::NBYTES-1:0]         entry_wstrb,
   input  logic                                 entry_pop,

   output logic                                 empty
);

   localparam int DEPTH = 2 ** WTB_DEPTH_W;

   logic [ADDR_W-1:cache_pkg::NBYTES_W]  addr_mem  [DEPTH];
   logic [cache_pkg::DATA_W-1:0]         wdata_mem [DEPTH];
   logic [cache_pkg::NBYTES-1:0]         wstrb_mem [DEPTH];

   logic [WTB_DEPTH_W:0]    wr_ptr;   // Extra MSB tells full from empty
   logic [WTB_DEPTH_W:0]    rd_ptr;
   logic [WTB_DEPTH_W-1:0]  wr_idx;
   logic [WTB_DEPTH_W-1:0]  rd_idx;
   logic                    full;
   logic                    push;
   logic                    pop;

   assign wr_idx = wr_ptr[WTB_DEPTH_W-1:0];
   assign rd_idx = rd_ptr[WTB_DEPTH_W-1:0];

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[WTB_DEPTH_W] != rd_ptr[WTB_DEPTH_W]) && (wr_idx == rd_idx);

   // A pop frees the slot a same-cycle push lands in
   assign write_ready = ~full | entry_pop;

   assign push = write_valid & write_ready;
   assign pop  = entry_pop & ~empty;

   always_ff @(posedge clk_i or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_idx]  <= write_addr;
         wdata_mem[wr_idx] <= write_wdata;
         wstrb_mem[wr_idx] <= write_wstrb;
      end
   end

   // Oldest entry
   assign entry_valid = ~empty;
   assign entry_addr  = addr_mem[rd_idx];
   assign entry_wdata = wdata_mem[rd_idx];
   assign entry_wstrb = wstrb_mem[rd_idx];

endmodule

//--- cache_pkg.sv
package cache_pkg;

   // Front-end byte address width
   localparam int ADDR_W = 32;

   // Word width, the same on the front and back side
   localparam int DATA_W = 32;

   localparam int NBYTES   = DATA_W / 8;       // Bytes per word, also strobe width
   localparam int NBYTES_W = $clog2(NBYTES);   // Byte offset bits

   // log2 of back-end beats per line
   localparam int LINE2BE_W = 2;

   // log2 of write-through buffer entries
   localparam int WTB_DEPTH_W = 2;

endpackage
